/* Bender.yml */
package:
  name: hdmi_tx

sources:
  - videoPkg.sv
  - tmdsPkg.sv
  - videoTiming.sv
  - tmdsEncoder.sv
  - tmdsSerializer.sv
  - hdmiTx.sv
  - target: test
    include_dirs:
      - .
    files:
      - hdmiTxTb.sv

/* hdmiTx.sv */
`timescale 1ns/10ps

module hdmiTx
#(
    parameter int hActive = videoPkg::defHActive,
    parameter int hFront  = videoPkg::defHFront,
    parameter int hSync   = videoPkg::defHSync,
    parameter int hBack   = videoPkg::defHBack,
    parameter int vActive = videoPkg::defVActive,
    parameter int vFront  = videoPkg::defVFront,
    parameter int vSync   = videoPkg::defVSync,
    parameter int vBack   = videoPkg::defVBack
)
(
    input  logic                              clk,
    input  logic                              clkTmds,  // 5x clk, phase locked
    input  logic                              rstn,
    input  logic [videoPkg::pixelWidth-1:0]   rgb,
    output logic [videoPkg::counterWidth-1:0] counterX,
    output logic [videoPkg::counterWidth-1:0] counterY,
    output logic                              drawArea,
    output logic                              request,
    output logic                              hdmiD0,
    output logic                              hdmiD1,
    output logic                              hdmiD2,
    output logic                              hdmiClk
);

    logic                             hSyncLvl;
    logic                             vSyncLvl;
    logic [videoPkg::colourWidth-1:0] pixRed;
    logic [videoPkg::colourWidth-1:0] pixGreen;
    logic [videoPkg::colourWidth-1:0] pixBlue;
    tmdsPkg::ctrlCode                 blueCtrl;
    logic [tmdsPkg::symbolWidth-1:0]  symRed;
    logic [tmdsPkg::symbolWidth-1:0]  symGreen;
    logic [tmdsPkg::symbolWidth-1:0]  symBlue;

    videoTiming
    #(
        .hActive (hActive),
        .hFront  (hFront),
        .hSync   (hSync),
        .hBack   (hBack),
        .vActive (vActive),
        .vFront  (vFront),
        .vSync   (vSync),
        .vBack   (vBack)
    ) timing_i
    (
        .clk      (clk),
        .rstn     (rstn),
        .counterX (counterX),
        .counterY (counterY),
        .request  (request),
        .drawArea (drawArea),
        .hSyncLvl (hSyncLvl),
        .vSyncLvl (vSyncLvl)
    );

    // pixel lands here on the edge that raises drawArea
    always_ff @(posedge clk)
    begin
        {pixRed, pixGreen, pixBlue} <= rgb;
    end

    ////////////////////////////////////////////////////////////////////////////
    // encoders and serializer
    ////////////////////////////////////////////////////////////////////////////

    assign blueCtrl = tmdsPkg::ctrlCode'({vSyncLvl, hSyncLvl});  // sync rides on blue

    tmdsEncoder encRed_i
    (
        .clk(clk), .rstn(rstn), .videoData(pixRed), .ctrl(tmdsPkg::ctrlNone),
        .videoEn(drawArea), .symbol(symRed)
    );

    tmdsEncoder encGreen_i
    (
        .clk(clk), .rstn(rstn), .videoData(pixGreen), .ctrl(tmdsPkg::ctrlNone),
        .videoEn(drawArea), .symbol(symGreen)
    );

    tmdsEncoder encBlue_i
    (
        .clk(clk), .rstn(rstn), .videoData(pixBlue), .ctrl(blueCtrl),
        .videoEn(drawArea), .symbol(symBlue)
    );

    tmdsSerializer ser_i
    (
        .clkTmds  (clkTmds),
        .rstn     (rstn),
        .symRed   (symRed),
        .symGreen (symGreen),
        .symBlue  (symBlue),
        .hdmiD2   (hdmiD2),
        .hdmiD1   (hdmiD1),
        .hdmiD0   (hdmiD0)
    );

    assign hdmiClk = clk;  // TMDS clock lane runs at the pixel rate

endmodule

/* tmdsRef.svh */
`ifndef TMDS_REF_SVH
`define TMDS_REF_SVH

// inverse of the two TMDS coding stages
function automatic logic [7:0] tmdsDecode(input logic [9:0] sym);
    logic [7:0] d;
    logic [7:0] data;
    d = sym[9] ? ~sym[7:0] : sym[7:0];  // undo the DC-balance inversion
    data[0] = d[0];
    for (int i = 1; i < 8; i++)
    begin
        data[i] = sym[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return data;
endfunction

// DVI control characters
function automatic logic [9:0] ctrlSymbolFor(input logic vs, input logic hs);
    case ({vs, hs})
        2'b00:   return 10'b1101010100;
        2'b01:   return 10'b0010101011;
        2'b10:   return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

// -1 when the word is no control character
function automatic int ctrlIndexOf(input logic [9:0] sym);
    for (int i = 0; i < 4; i++)
    begin
        if (sym === ctrlSymbolFor(i[1], i[0]))
        begin
            return i;
        end
    end
    return -1;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* hdmiTxTb.sv */
`timescale 1ns/10ps

module hdmiTxTb;

    // small raster, 25 pixels by 10 lines
    localparam int hActive = 16;
    localparam int hFront  = 2;
    localparam int hSync   = 4;
    localparam int hBack   = 3;
    localparam int vActive = 6;
    localparam int vFront  = 1;
    localparam int vSync   = 2;
    localparam int vBack   = 1;
    localparam int hTotal  = hSync + hBack + hActive + hFront;
    localparam int vTotal  = vSync + vBack + vActive + vFront;

    logic                              clk     = 1'b0;
    logic                              clkTmds = 1'b0;
    logic                              rstn    = 1'b1;
    logic [videoPkg::pixelWidth-1:0]   rgb     = '0;
    logic [videoPkg::counterWidth-1:0] counterX;
    logic [videoPkg::counterWidth-1:0] counterY;
    logic                              drawArea;
    logic                              request;
    logic                              hdmiD0;
    logic                              hdmiD1;
    logic                              hdmiD2;
    logic                              hdmiClk;

    int          checkCount    = 0;
    int          mismatchCount = 0;
    int          otherCount    = 0;
    logic [23:0] pixQ[$];                  // pixels handed to the DUT, oldest first
    logic [31:0] rngState      = 32'd58;
    int          prevX;
    int          prevY;
    logic        prevDraw;
    bit          havePrev      = 1'b0;
    logic [2:0]  reqHist       = '0;       // request one, two, three cycles back
    logic [9:0]  winR          = '0;
    logic [9:0]  winG          = '0;
    logic [9:0]  winB          = '0;
    logic [9:0]  prevBlue      = '0;
    int          sinceCtrl     = 0;
    int          bitCount      = 0;
    bit          seenCtrl      = 1'b0;
    bit          locked        = 1'b0;
    bit          synced        = 1'b0;
    int          wordX;                    // raster position of the word on the pins
    int          wordY;
    int          balR          = 0;
    int          balG          = 0;
    int          balB          = 0;
    int          framesChecked = 0;
    int          pixelsChecked = 0;

    `include "tmdsRef.svh"

    hdmiTx
    #(
        .hActive (hActive), .hFront (hFront), .hSync (hSync), .hBack (hBack),
        .vActive (vActive), .vFront (vFront), .vSync (vSync), .vBack (vBack)
    ) dut_i
    (
        .clk      (clk),
        .clkTmds  (clkTmds),
        .rstn     (rstn),
        .rgb      (rgb),
        .counterX (counterX),
        .counterY (counterY),
        .drawArea (drawArea),
        .request  (request),
        .hdmiD0   (hdmiD0),
        .hdmiD1   (hdmiD1),
        .hdmiD2   (hdmiD2),
        .hdmiClk  (hdmiClk)
    );

    initial
    begin
        forever #2 clk = ~clk;
    end

    initial
    begin
        forever #0.4 clkTmds = ~clkTmds;  // edges line up with clk
    end

    function automatic logic inWindow(input int x, input int y);
        return x >= hSync + hBack && x < hSync + hBack + hActive
            && y >= vSync + vBack && y < vSync + vBack + vActive;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            mismatchCount++;
            $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond)
        else
        begin
            otherCount++;
            $display("FAILURE t=%0t %s", $time, what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // pixel source
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (request === 1'b1)
        begin
            rngState = xorshift32(rngState);
            rgb <= rngState[23:0];
            if (synced)
            begin
                pixQ.push_back(rngState[23:0]);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // counters and window timing
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rstn !== 1'b1)
        begin
            havePrev = 1'b0;
            reqHist  = '0;
        end
        else
        begin
            checkTrue(counterX < hTotal, "counterX reached the line total");
            checkTrue(counterY < vTotal, "counterY reached the frame total");
            if (havePrev)
            begin
                compareValue("counterX", counterX, (prevX == hTotal - 1) ? 0 : prevX + 1);
                if (prevX != hTotal - 1)
                begin
                    compareValue("counterY", counterY, prevY);
                end
                else
                begin
                    compareValue("counterY", counterY, (prevY == vTotal - 1) ? 0 : prevY + 1);
                end
                compareValue("drawArea", drawArea, inWindow(prevX, prevY));  // one cycle late
                if (drawArea && !prevDraw)
                begin
                    checkTrue(reqHist[1] && !reqHist[2],
                              "drawArea rose without a request rise two cycles before");
                end
            end
            checkTrue(!request || (counterY >= vSync + vBack && counterY < vSync + vBack + vActive),
                      "request high outside the vertical active window");
            reqHist  = {reqHist[1:0], request};
            prevX    = counterX;
            prevY    = counterY;
            prevDraw = drawArea;
            havePrev = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // deserializer and symbol checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic takeWord();
        logic [23:0] expPix;
        if (!synced && winB === ctrlSymbolFor(1, 1) && prevBlue === ctrlSymbolFor(0, 0))
        begin
            synced = 1'b1;  // hsync and vsync rise together at the frame start
            wordX  = 0;
            wordY  = 0;
        end
        prevBlue = winB;
        if (synced)
        begin
            if (inWindow(wordX, wordY))
            begin
                if (pixQ.size() == 0)
                begin
                    checkTrue(1'b0, "data symbol arrived with no pixel queued");
                end
                else
                begin
                    expPix = pixQ.pop_front();
                    compareValue("hdmiD2 red", tmdsDecode(winR), expPix[23:16]);
                    compareValue("hdmiD1 green", tmdsDecode(winG), expPix[15:8]);
                    compareValue("hdmiD0 blue", tmdsDecode(winB), expPix[7:0]);
                    pixelsChecked++;
                end
                balR += 2 * $countones(winR) - 10;
                balG += 2 * $countones(winG) - 10;
                balB += 2 * $countones(winB) - 10;
                checkTrue(balR >= -10 && balR <= 10 && balG >= -10 && balG <= 10
                          && balB >= -10 && balB <= 10, "running disparity left +-10 bits");
            end
            else
            begin
                compareValue("hdmiD0 control", winB, ctrlSymbolFor(wordY < vSync, wordX < hSync));
                compareValue("hdmiD1 control", winG, ctrlSymbolFor(0, 0));
                compareValue("hdmiD2 control", winR, ctrlSymbolFor(0, 0));
                balR = 0;
                balG = 0;
                balB = 0;
            end
            if (wordX == hTotal - 1)
            begin
                checkTrue(pixQ.size() == 0, "pixel queue not empty at the line end");
                wordX = 0;
                wordY = (wordY == vTotal - 1) ? 0 : wordY + 1;
                framesChecked += (wordY == 0);
            end
            else
            begin
                wordX++;
            end
        end
    endtask

    always @(clkTmds)
    begin
        #0.2;  // middle of the half period
        compareValue("hdmiClk", hdmiClk, clk);  // clock lane is the pixel clock
        if (rstn === 1'b1)
        begin
            winB = {hdmiD0, winB[9:1]};  // bit 0 arrives first
            winG = {hdmiD1, winG[9:1]};
            winR = {hdmiD2, winR[9:1]};
            if (!locked)
            begin
                sinceCtrl++;
                if (ctrlIndexOf(winB) >= 0)
                begin
                    locked    = seenCtrl && sinceCtrl == 10;
                    seenCtrl  = 1'b1;
                    sinceCtrl = 0;
                    prevBlue  = winB;
                end
            end
            else
            begin
                bitCount++;
                if (bitCount == 10)
                begin
                    bitCount = 0;
                    takeWord();
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int waitCycles;
        rstn <= 1'b0;
        repeat (16)
        begin
            @(posedge clk);
            compareValue("drawArea", drawArea, 0);
            compareValue("hdmiD2..0", {hdmiD2, hdmiD1, hdmiD0}, 0);
        end
        rstn <= 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            compareValue("drawArea", drawArea, 0);
            if (i == 0)
            begin
                compareValue("hdmiD2..0", {hdmiD2, hdmiD1, hdmiD0}, 0);
            end
        end

        waitCycles = 0;
        while (!synced && waitCycles < 600)
        begin
            @(posedge clk);
            waitCycles++;
        end
        if (!locked)
        begin
            checkTrue(1'b0, "blue lane never showed two control symbols ten bits apart");
        end
        else if (!synced)
        begin
            checkTrue(1'b0, "timed out waiting for a frame start on the blue lane");
        end

        waitCycles = 0;
        while (synced && framesChecked < 2 && waitCycles < 1000)
        begin
            @(posedge clk);
            waitCycles++;
        end
        checkTrue(framesChecked >= 2, "timed out waiting for two checked frames");
        checkTrue(pixelsChecked > 0, "no pixel reached the serial pins");

        $display("checks %0d, mismatches %0d, other failures %0d, pixels %0d",
                 checkCount, mismatchCount, otherCount, pixelsChecked);
        if (mismatchCount == 0 && otherCount == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tmdsEncoder.sv */
`timescale 1ns/10ps

module tmdsEncoder
(
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [7:0]                      videoData,
    input  tmdsPkg::ctrlCode                ctrl,
    input  logic                            videoEn,
    output logic [tmdsPkg::symbolWidth-1:0] symbol
);

    logic [3:0]                      dataOnes;
    logic                            useXnor;
    logic [8:0]                      qm;         // transition-minimised word
    logic [3:0]                      qmOnes;
    logic signed [3:0]               qmBalance;  // (ones - zeros) / 2
    logic signed [3:0]               dispAcc;    // running disparity, half units
    logic signed [3:0]               dispNext;
    logic                            invert;
    logic [tmdsPkg::symbolWidth-1:0] dataSym;
    logic [tmdsPkg::symbolWidth-1:0] ctrlSym;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 transition minimisation
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        dataOnes = '0;
        for (int i = 0; i < 8; i++)
        begin
            dataOnes = dataOnes + 4'(videoData[i]);
        end
    end

    // xnor when the byte is ones-heavy
    assign useXnor = (dataOnes > 4'd4) || (dataOnes == 4'd4 && !videoData[0]);

    always_comb
    begin
        qm[0] = videoData[0];
        for (int i = 1; i < 8; i++)
        begin
            qm[i] = qm[i-1] ^ videoData[i] ^ useXnor;
        end
        qm[8] = !useXnor;  // tells the sink which op was used
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 DC balance
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        qmOnes = '0;
        for (int i = 0; i < 8; i++)
        begin
            qmOnes = qmOnes + 4'(qm[i]);
        end
    end

    assign qmBalance = signed'(qmOnes - 4'd4);

    always_comb
    begin
        if (dispAcc == 0 || qmBalance == 0)
        begin
            // neutral word or neutral line so far
            invert   = !qm[8];
            dispNext = qm[8] ? dispAcc + qmBalance : dispAcc - qmBalance;
        end
        else if (dispAcc[3] == qmBalance[3])
        begin
            invert   = 1'b1;  // same sign, pull back toward zero
            dispNext = dispAcc - qmBalance + signed'({3'b000, qm[8]});
        end
        else
        begin
            invert   = 1'b0;
            dispNext = dispAcc + qmBalance - signed'({3'b000, !qm[8]});
        end
    end

    assign dataSym = {invert, qm[8], qm[7:0] ^ {8{invert}}};

    // control period
    always_comb
    begin
        unique case (ctrl)
            tmdsPkg::ctrlNone:  ctrlSym = tmdsPkg::ctrlSymbol0;
            tmdsPkg::ctrlHsync: ctrlSym = tmdsPkg::ctrlSymbol1;
            tmdsPkg::ctrlVsync: ctrlSym = tmdsPkg::ctrlSymbol2;
            tmdsPkg::ctrlBoth:  ctrlSym = tmdsPkg::ctrlSymbol3;
            default:            ctrlSym = tmdsPkg::ctrlSymbol0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            dispAcc <= '0;
        end
        else
        begin
            dispAcc <= videoEn ? dispNext : '0;  // each line starts balanced
        end
    end

    always_ff @(posedge clk)
    begin
        symbol <= videoEn ? dataSym : ctrlSym;
    end

endmodule

/* tmdsPkg.sv */
package tmdsPkg;

    localparam int symbolWidth = 10;  // one TMDS character

    ////////////////////////////////////////////////////////////////////////////
    // control period
    ////////////////////////////////////////////////////////////////////////////

    // bit 0 carries hsync, bit 1 carries vsync
    typedef enum logic [1:0]
    {
        ctrlNone  = 2'b00,
        ctrlHsync = 2'b01,
        ctrlVsync = 2'b10,
        ctrlBoth  = 2'b11
    } ctrlCode;

    // DVI control characters, indexed by ctrlCode
    localparam logic [symbolWidth-1:0] ctrlSymbol0 = 10'b1101010100;
    localparam logic [symbolWidth-1:0] ctrlSymbol1 = 10'b0010101011;
    localparam logic [symbolWidth-1:0] ctrlSymbol2 = 10'b0101010100;
    localparam logic [symbolWidth-1:0] ctrlSymbol3 = 10'b1010101011;

    // each control character has seven transitions, more than
    // any data character has, so a sink can find word boundaries

endpackage

/* tmdsSerializer.sv */
`timescale 1ns/10ps

module tmdsSerializer
(
    input  logic                            clkTmds,
    input  logic                            rstn,
    input  logic [tmdsPkg::symbolWidth-1:0] symRed,
    input  logic [tmdsPkg::symbolWidth-1:0] symGreen,
    input  logic [tmdsPkg::symbolWidth-1:0] symBlue,
    output logic                            hdmiD2,
    output logic                            hdmiD1,
    output logic                            hdmiD0
);

    localparam int symW       = tmdsPkg::symbolWidth;
    localparam int loadPeriod = symW / 2;  // two bits per fast cycle

    logic [2:0]           phase;
    logic                 load;
    logic [2:0][symW-1:0] lane;      // 2 red, 1 green, 0 blue
    logic [2:0][symW-1:0] shifter;
    logic [2:0]           riseQ;
    logic [2:0]           fallHold;  // d1 captured on the rising edge
    logic [2:0]           fallQ;
    logic [2:0]           laneOut;

    ////////////////////////////////////////////////////////////////////////////
    // load phase
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clkTmds or negedge rstn)
    begin
        if (!rstn)
        begin
            phase <= '0;
        end
        else
        begin
            phase <= load ? '0 : phase + 1'b1;
        end
    end

    assign load = (phase == 3'(loadPeriod - 1));

    ////////////////////////////////////////////////////////////////////////////
    // shifters
    ////////////////////////////////////////////////////////////////////////////

    assign lane = {symRed, symGreen, symBlue};

    always_ff @(posedge clkTmds or negedge rstn)
    begin
        if (!rstn)
        begin
            shifter <= '0;
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                // lsb leaves first
                shifter[i] <= load ? lane[i] : {2'b00, shifter[i][symW-1:2]};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // DDR output stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clkTmds or negedge rstn)
    begin
        if (!rstn)
        begin
            riseQ    <= '0;
            fallHold <= '0;
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                riseQ[i]    <= shifter[i][0];  // driven while clkTmds is high
                fallHold[i] <= shifter[i][1];
            end
        end
    end

    always_ff @(negedge clkTmds or negedge rstn)
    begin
        if (!rstn)
        begin
            fallQ <= '0;
        end
        else
        begin
            fallQ <= fallHold;
        end
    end

    assign laneOut = clkTmds ? riseQ : fallQ;

    assign hdmiD2 = laneOut[2];
    assign hdmiD1 = laneOut[1];
    assign hdmiD0 = laneOut[0];

endmodule

/* verilog.f */
+incdir+.
videoPkg.sv
tmdsPkg.sv
videoTiming.sv
tmdsEncoder.sv
tmdsSerializer.sv
hdmiTx.sv
hdmiTxTb.sv

/* videoPkg.sv */
package videoPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int counterWidth = 16;               // pixel and line counters
    localparam int colourWidth  = 8;                // bits per colour channel
    localparam int pixelWidth   = 3 * colourWidth;  // red in the top byte

    ////////////////////////////////////////////////////////////////////////////
    // default timing, 640x480 at 60 Hz
    ////////////////////////////////////////////////////////////////////////////

    // horizontal, in pixels
    localparam int defHActive = 640;
    localparam int defHFront  = 16;
    localparam int defHSync   = 96;
    localparam int defHBack   = 48;

    // vertical, in lines
    localparam int defVActive = 480;
    localparam int defVFront  = 10;
    localparam int defVSync   = 2;
    localparam int defVBack   = 33;

endpackage

/* videoTiming.sv */
`timescale 1ns/10ps

module videoTiming
#(
    parameter int hActive = videoPkg::defHActive,
    parameter int hFront  = videoPkg::defHFront,
    parameter int hSync   = videoPkg::defHSync,
    parameter int hBack   = videoPkg::defHBack,
    parameter int vActive = videoPkg::defVActive,
    parameter int vFront  = videoPkg::defVFront,
    parameter int vSync   = videoPkg::defVSync,
    parameter int vBack   = videoPkg::defVBack
)
(
    input  logic                              clk,
    input  logic                              rstn,
    output logic [videoPkg::counterWidth-1:0] counterX,
    output logic [videoPkg::counterWidth-1:0] counterY,
    output logic                              request,
    output logic                              drawArea,
    output logic                              hSyncLvl,
    output logic                              vSyncLvl
);

    localparam int cw = videoPkg::counterWidth;

    // sync, back porch, active, front porch
    localparam logic [cw-1:0] hLast    = cw'(hSync + hBack + hActive + hFront - 1);
    localparam logic [cw-1:0] hStart   = cw'(hSync + hBack);
    localparam logic [cw-1:0] hEnd     = cw'(hSync + hBack + hActive);
    localparam logic [cw-1:0] reqStart = cw'(hSync + hBack - 1);  // one pixel ahead
    localparam logic [cw-1:0] reqEnd   = cw'(hSync + hBack + hActive - 1);
    localparam logic [cw-1:0] hSyncEnd = cw'(hSync);

    localparam logic [cw-1:0] vLast    = cw'(vSync + vBack + vActive + vFront - 1);
    localparam logic [cw-1:0] vStart   = cw'(vSync + vBack);
    localparam logic [cw-1:0] vEnd     = cw'(vSync + vBack + vActive);
    localparam logic [cw-1:0] vSyncEnd = cw'(vSync);

    logic lineEnd;
    logic hWindow;
    logic hAhead;
    logic vWindow;

    ////////////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////////////

    assign lineEnd = (counterX == hLast);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            counterX <= '0;
        end
        else
        begin
            counterX <= lineEnd ? '0 : counterX + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            counterY <= '0;
        end
        else if (lineEnd)
        begin
            counterY <= (counterY == vLast) ? '0 : counterY + 1'b1;  // frame wrap
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // windows
    ////////////////////////////////////////////////////////////////////////////

    assign hWindow = (counterX >= hStart) && (counterX < hEnd);
    assign hAhead  = (counterX >= reqStart) && (counterX < reqEnd);
    assign vWindow = (counterY >= vStart) && (counterY < vEnd);

    // lookahead for a frame buffer with one cycle of read latency
    assign request = hAhead && vWindow;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            drawArea <= 1'b0;
            hSyncLvl <= 1'b0;
            vSyncLvl <= 1'b0;
        end
        else
        begin
            drawArea <= hWindow && vWindow;
            hSyncLvl <= (counterX < hSyncEnd);  // sync comes first in the line
            vSyncLvl <= (counterY < vSyncEnd);
        end
    end

endmodule
